// ==== bench/phy_rx_tb.sv ====
// testbench for the receive path with reference 8b/10b encoder, framing model and checks
`timescale 1ns/100ps
`include "phy_rx_defines.svh"

module phy_rx_tb import phy_rx_pkg::*; ();

    // expected flag bits carried with each word
    localparam int F_CHK  = 5;
    localparam int F_FV   = 4;
    localparam int F_SV   = 3;
    localparam int F_LAST = 2;
    localparam int F_CERR = 1;
    localparam int F_FERR = 0;

    logic       CLK;
    logic       nRST;
    enc_word_t  enc_word;
    logic       word_valid;
    flit_t      flit;
    logic       flit_valid;
    comma_sel_t comma_sel;
    logic       sel_valid;
    logic       pkt_last;
    pkt_count_t pkt_count;
    logic       code_err;
    logic       frame_err;

    logic [31:0] lcg_state;
    logic        run_disp;
    int          cycle = 0;
    logic        pkt_open;
    logic        hdr_pending;
    int          remaining;

    int          q_due[$];
    flit_t       q_flit[$];
    comma_sel_t  q_sel[$];
    logic [5:0]  q_flags[$];
    flit_t       chk_flit;
    logic [5:0]  chk_flags;
    comma_sel_t  exp_sel;
    pkt_count_t  exp_count;

    phy_rx_top UUT (
        .CLK        (CLK),
        .nRST       (nRST),
        .enc_word   (enc_word),
        .word_valid (word_valid),
        .flit       (flit),
        .flit_valid (flit_valid),
        .comma_sel  (comma_sel),
        .sel_valid  (sel_valid),
        .pkt_last   (pkt_last),
        .pkt_count  (pkt_count),
        .code_err   (code_err),
        .frame_err  (frame_err)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        stop_with_fail($sformatf("mismatch at %0t: %s got %0h expected %0h",
                                 $time, name, got, exp));
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic flit_t rand_flit();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand();
        b = next_rand();
        return {a[31:24], b};
    endfunction

    // data symbol with running disparity, {abcdei, fghj}
    function automatic logic [9:0] encode_byte(input logic [7:0] b);
        logic [5:0] six;
        logic [3:0] four;
        logic       alt;
        case (b[4:0])
            5'd0:  six = 6'b100111;
            5'd1:  six = 6'b011101;
            5'd2:  six = 6'b101101;
            5'd3:  six = 6'b110001;
            5'd4:  six = 6'b110101;
            5'd5:  six = 6'b101001;
            5'd6:  six = 6'b011001;
            5'd7:  six = 6'b111000;
            5'd8:  six = 6'b111001;
            5'd9:  six = 6'b100101;
            5'd10: six = 6'b010101;
            5'd11: six = 6'b110100;
            5'd12: six = 6'b001101;
            5'd13: six = 6'b101100;
            5'd14: six = 6'b011100;
            5'd15: six = 6'b010111;
            5'd16: six = 6'b011011;
            5'd17: six = 6'b100011;
            5'd18: six = 6'b010011;
            5'd19: six = 6'b110010;
            5'd20: six = 6'b001011;
            5'd21: six = 6'b101010;
            5'd22: six = 6'b011010;
            5'd23: six = 6'b111010;
            5'd24: six = 6'b110011;
            5'd25: six = 6'b100110;
            5'd26: six = 6'b010110;
            5'd27: six = 6'b110110;
            5'd28: six = 6'b001110;
            5'd29: six = 6'b101110;
            5'd30: six = 6'b011110;
            default: six = 6'b101011;
        endcase
        if (run_disp && ($countones(six) != 3 || b[4:0] == 5'd7)) six = ~six;
        if ($countones(six) != 3) run_disp = ~run_disp;
        // alternate x.7 avoids a run of five equal bits
        alt = run_disp ? (b[4:0] inside {5'd11, 5'd13, 5'd14})
                       : (b[4:0] inside {5'd17, 5'd18, 5'd20});
        case (b[7:5])
            3'd0: four = 4'b1011;
            3'd1: four = 4'b1001;
            3'd2: four = 4'b0101;
            3'd3: four = 4'b1100;
            3'd4: four = 4'b1101;
            3'd5: four = 4'b1010;
            3'd6: four = 4'b0110;
            default: four = alt ? 4'b0111 : 4'b1110;
        endcase
        if (run_disp && ($countones(four) != 2 || b[7:5] == 3'd3)) four = ~four;
        if ($countones(four) != 2) run_disp = ~run_disp;
        return {six, four};
    endfunction

    // K28.y control symbol
    function automatic logic [9:0] encode_k28(input logic [2:0] y);
        logic [3:0] four;
        logic [9:0] code;
        case (y)
            3'd0: four = 4'b0100;
            3'd1: four = 4'b1001;
            3'd2: four = 4'b0101;
            3'd3: four = 4'b0011;
            3'd4: four = 4'b0010;
            3'd5: four = 4'b1010;
            3'd6: four = 4'b0110;
            default: four = 4'b1000;
        endcase
        code = {6'b001111, four};
        if (run_disp) code = ~code;
        if ($countones(code) != 5) run_disp = ~run_disp;
        return code;
    endfunction

    function automatic enc_word_t fill_random_syms(input enc_word_t w, input int first);
        logic [31:0] r;
        for (int i = first; i < `PHY_SYMBOLS; i++) begin
            r = next_rand();
            w[i*`PHY_SYM_W +: `PHY_SYM_W] = encode_byte(r[31:24]);
        end
        return w;
    endfunction

    // total flits of a packet from its header payload
    function automatic int model_flits(input logic [31:0] p);
        int len;
        int num;
        len = (p[7:0] == 8'h0) ? `PHY_LONG_LEN_DEFAULT : int'(p[7:0]);
        case (p[31:28])
            FMT_SHORT_READ:        num = 1;
            FMT_LONG_READ:         num = 2;
            FMT_SHORT_WRITE:       num = 1 + ((p[3:0] == 4'h0) ? `PHY_SHORT_LEN_DEFAULT
                                                               : int'(p[3:0]));
            FMT_LONG_WRITE:        num = 2 + len;
            FMT_MSG, FMT_MEM_RESP: num = 1 + len;
            default:               num = 1;
        endcase
        return num;
    endfunction

    task automatic drive_word(input enc_word_t w, input flit_t f, input comma_sel_t s,
                              input logic [5:0] flags);
        @(posedge CLK);
        #1;
        enc_word = w;
        word_valid = 1'b1;
        q_due.push_back(cycle + 3);
        q_flit.push_back(f);
        q_sel.push_back(s);
        q_flags.push_back(flags);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
            word_valid = 1'b0;
        end
    endtask

    task automatic random_gap();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] == 2'b00) idle_cycles(int'(r[29:28]) + 1);
    endtask

    // start or end comma in symbol 0
    task automatic send_frame_comma(input logic is_start);
        enc_word_t w;
        logic      ferr;
        w = '0;
        w[`PHY_SYM_W-1:0] = encode_k28(is_start ? 3'd5 : 3'd7);
        w = fill_random_syms(w, 1);
        ferr = pkt_open;
        pkt_open = is_start;
        hdr_pending = is_start;
        drive_word(w, '0, is_start ? START_SEL : END_SEL, {4'b0010, 1'b0, ferr});
    endtask

    // link control comma in symbol 1, control fields in symbol 0
    task automatic send_link_ctrl(input comma_sel_t sel, input logic [2:0] y);
        enc_word_t   w;
        logic [31:0] r;
        r = next_rand();
        w = '0;
        w[`PHY_SYM_W-1:0] = encode_byte(r[31:24]);
        w[2*`PHY_SYM_W-1:`PHY_SYM_W] = encode_k28(y);
        w = fill_random_syms(w, 2);
        drive_word(w, {r[31:24], 32'h0}, sel, 6'b101000);
    endtask

    task automatic send_data(input flit_t f, input int bad_sym);
        enc_word_t w;
        logic      last;
        logic      ferr;
        for (int i = 0; i < `PHY_SYMBOLS; i++) begin
            w[i*`PHY_SYM_W +: `PHY_SYM_W] = encode_byte(f[i*`PHY_BYTE_W +: `PHY_BYTE_W]);
        end
        // all zero is outside both tables
        if (bad_sym >= 0) w[bad_sym*`PHY_SYM_W +: `PHY_SYM_W] = '0;
        last = 1'b0;
        ferr = 1'b0;
        if (hdr_pending) begin
            hdr_pending = 1'b0;
            remaining = model_flits(f[31:0]) - 1;
        end else if (pkt_open) begin
            remaining--;
        end else begin
            ferr = 1'b1;
        end
        if (pkt_open && remaining == 0) begin
            last = 1'b1;
            pkt_open = 1'b0;
        end
        drive_word(w, f, DATA_SEL, {bad_sym < 0, 2'b10, last, bad_sym >= 0, ferr});
    endtask

    task automatic send_packet(input logic [3:0] fmt, input logic [7:0] len);
        flit_t       f;
        logic [31:0] r;
        int          n;
        f = rand_flit();
        f[31:28] = fmt;
        f[7:0] = len;
        n = model_flits(f[31:0]);
        send_frame_comma(1'b1);
        random_gap();
        send_data(f, -1);
        for (int i = 1; i < n; i++) begin
            random_gap();
            r = next_rand();
            send_data(rand_flit(), (r[31:28] == 4'h0) ? int'(r[27:24]) % 5 : -1);
        end
        random_gap();
        send_frame_comma(1'b0);
    endtask

    // outputs settle well before the falling edge
    always @(negedge CLK) begin
        if (cycle > 0) begin
            chk_flags = '0;
            if (q_due.size() != 0 && q_due[0] == cycle) begin
                void'(q_due.pop_front());
                chk_flags = q_flags.pop_front();
                chk_flit = q_flit.pop_front();
                exp_sel = q_sel.pop_front();
                if (chk_flags[F_LAST]) exp_count = exp_count + pkt_count_t'(1);
            end
            assert (flit_valid === chk_flags[F_FV])
                else report_mismatch("flit_valid", flit_valid, chk_flags[F_FV]);
            assert (sel_valid === chk_flags[F_SV])
                else report_mismatch("sel_valid", sel_valid, chk_flags[F_SV]);
            assert (pkt_last === chk_flags[F_LAST])
                else report_mismatch("pkt_last", pkt_last, chk_flags[F_LAST]);
            assert (code_err === chk_flags[F_CERR])
                else report_mismatch("code_err", code_err, chk_flags[F_CERR]);
            assert (frame_err === chk_flags[F_FERR])
                else report_mismatch("frame_err", frame_err, chk_flags[F_FERR]);
            assert (comma_sel === exp_sel)
                else report_mismatch("comma_sel", comma_sel, exp_sel);
            assert (pkt_count === exp_count)
                else report_mismatch("pkt_count", pkt_count, exp_count);
            assert (!chk_flags[F_CHK] || flit === chk_flit)
                else report_mismatch("flit", flit, chk_flit);
        end
    end

    initial begin
        logic [3:0]  fmts [7];
        flit_t       f;
        logic [31:0] r;
        int          wait_cnt;
        nRST = 1'b0;
        word_valid = 1'b0;
        enc_word = '0;
        lcg_state = 32'hf6d62094;
        run_disp = 1'b0;
        pkt_open = 1'b0;
        hdr_pending = 1'b0;
        remaining = 0;
        exp_sel = START_SEL;
        exp_count = '0;
        fmts = '{FMT_SHORT_READ, FMT_LONG_READ, FMT_SHORT_WRITE, FMT_LONG_WRITE,
                 FMT_MSG, FMT_MEM_RESP, 4'hc};
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;
        idle_cycles(3);

        // data with no packet open, then an end with nothing open
        send_data(rand_flit(), -1);
        send_frame_comma(1'b0);
        // long read whose second flit has a bad symbol
        f = rand_flit();
        f[31:28] = FMT_LONG_READ;
        send_frame_comma(1'b1);
        send_data(f, -1);
        send_data(rand_flit(), 2);
        send_frame_comma(1'b0);
        // end comma arrives while flits are still expected
        f[31:28] = FMT_SHORT_WRITE;
        f[3:0] = 4'd5;
        send_frame_comma(1'b1);
        send_data(f, -1);
        send_data(rand_flit(), -1);
        send_frame_comma(1'b0);
        // start inside an open packet
        f[31:28] = FMT_SHORT_READ;
        send_frame_comma(1'b1);
        send_frame_comma(1'b1);
        send_data(f, -1);
        send_frame_comma(1'b0);

        send_link_ctrl(RESEND0_SEL, 3'd0);
        send_link_ctrl(RESEND1_SEL, 3'd1);
        idle_cycles(2);
        send_link_ctrl(RESEND2_SEL, 3'd2);
        send_link_ctrl(RESEND3_SEL, 3'd3);
        send_link_ctrl(ACK_SEL, 3'd4);
        send_link_ctrl(NACK_SEL, 3'd6);

        for (int k = 0; k < 7; k++) begin
            r = next_rand();
            send_packet(fmts[k], r[31:24]);
            random_gap();
            send_packet(fmts[k], 8'h0);
            random_gap();
        end

        idle_cycles(1);
        wait_cnt = 0;
        while (q_due.size() != 0 && wait_cnt < 20) begin
            @(posedge CLK);
            wait_cnt++;
        end
        if (q_due.size() != 0) begin
            stop_with_fail("timeout while waiting for the last words to leave the pipeline");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== build.f ====
+incdir+include
rtl/phy_rx_pkg.sv
rtl/dec_8b10b.sv
rtl/comma_classifier.sv
rtl/flit_decoder.sv
rtl/packet_counter.sv
rtl/phy_rx_top.sv
bench/phy_rx_tb.sv

// ==== include/phy_rx_defines.svh ====
// symbol count, symbol and byte widths, default packet lengths
`ifndef PHY_RX_DEFINES_SVH
`define PHY_RX_DEFINES_SVH

// 8b/10b symbols carried in one word
`define PHY_SYMBOLS 5
`define PHY_SYM_W 10
`define PHY_BYTE_W 8

// lengths used when a header length field reads zero
`define PHY_LONG_LEN_DEFAULT 128
`define PHY_SHORT_LEN_DEFAULT 16

`endif

// ==== rtl/comma_classifier.sv ====
// stage 1 word register and comma classification
`timescale 1ns/100ps
`include "phy_rx_defines.svh"

module comma_classifier import phy_rx_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  enc_word_t     enc_word,
    input  logic          word_valid,
    output enc_word_t     s1_word,
    output logic          s1_valid,
    output comma_length_t s1_length
);

    comma_sel_t    sel0;
    comma_sel_t    sel1;
    comma_length_t n_length;

    // start and end live in symbol 0, link control commas in symbol 1
    always_comb begin
        sel0 = comma_code_sel(enc_word[`PHY_SYM_W-1:0]);
        sel1 = comma_code_sel(enc_word[2*`PHY_SYM_W-1:`PHY_SYM_W]);
        if (sel0 inside {START_SEL, END_SEL}) begin
            n_length = COMMA_1_FLIT;
        end else if (sel1 inside {RESEND0_SEL, RESEND1_SEL, RESEND2_SEL, RESEND3_SEL,
                                  ACK_SEL, NACK_SEL}) begin
            n_length = COMMA_2_FLIT;
        end else begin
            n_length = COMMA_DATA;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            s1_valid  <= 1'b0;
            s1_length <= COMMA_DATA;
        end else begin
            s1_valid <= word_valid;
            if (word_valid) begin
                s1_length <= n_length;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (word_valid) begin
            s1_word <= enc_word;
        end
    end

endmodule

// ==== rtl/dec_8b10b.sv ====
// 8b/10b symbol decoder with K flag and code error
`timescale 1ns/100ps

module dec_8b10b import phy_rx_pkg::*; (
    input  sym_t  sym,
    output byte_t data,
    output logic  is_k,
    output logic  code_err
);

    logic [5:0] abcdei;
    logic [3:0] fghj;
    logic [3:0] fghj_dec;
    logic [4:0] edcba;
    logic [2:0] hgf;
    logic       err_6b;
    logic       err_4b;
    logic       k28;
    logic       kx7;

    assign abcdei = sym[9:4];
    assign fghj   = sym[3:0];
    assign k28    = (abcdei == 6'b001111) || (abcdei == 6'b110000);

    // K28 in positive disparity carries the complement of its 4b code
    assign fghj_dec = (abcdei == 6'b110000) ? ~fghj : fghj;

    // 5b/6b table, both disparities
    always_comb begin
        err_6b = 1'b0;
        case (abcdei)
            6'b100111, 6'b011000: edcba = 5'd0;
            6'b011101, 6'b100010: edcba = 5'd1;
            6'b101101, 6'b010010: edcba = 5'd2;
            6'b110001:            edcba = 5'd3;
            6'b110101, 6'b001010: edcba = 5'd4;
            6'b101001:            edcba = 5'd5;
            6'b011001:            edcba = 5'd6;
            6'b111000, 6'b000111: edcba = 5'd7;
            6'b111001, 6'b000110: edcba = 5'd8;
            6'b100101:            edcba = 5'd9;
            6'b010101:            edcba = 5'd10;
            6'b110100:            edcba = 5'd11;
            6'b001101:            edcba = 5'd12;
            6'b101100:            edcba = 5'd13;
            6'b011100:            edcba = 5'd14;
            6'b010111, 6'b101000: edcba = 5'd15;
            6'b011011, 6'b100100: edcba = 5'd16;
            6'b100011:            edcba = 5'd17;
            6'b010011:            edcba = 5'd18;
            6'b110010:            edcba = 5'd19;
            6'b001011:            edcba = 5'd20;
            6'b101010:            edcba = 5'd21;
            6'b011010:            edcba = 5'd22;
            6'b111010, 6'b000101: edcba = 5'd23;
            6'b110011, 6'b001100: edcba = 5'd24;
            6'b100110:            edcba = 5'd25;
            6'b010110:            edcba = 5'd26;
            6'b110110, 6'b001001: edcba = 5'd27;
            6'b001110:            edcba = 5'd28;
            6'b101110, 6'b010001: edcba = 5'd29;
            6'b011110, 6'b100001: edcba = 5'd30;
            6'b101011, 6'b010100: edcba = 5'd31;
            6'b001111, 6'b110000: edcba = 5'd28;
            default: begin
                edcba  = 5'd0;
                err_6b = 1'b1;
            end
        endcase
    end

    // 3b/4b table, primary and alternate x.7 included
    always_comb begin
        err_4b = 1'b0;
        case (fghj_dec)
            4'b1011, 4'b0100: hgf = 3'd0;
            4'b1001:          hgf = 3'd1;
            4'b0101:          hgf = 3'd2;
            4'b1100, 4'b0011: hgf = 3'd3;
            4'b1101, 4'b0010: hgf = 3'd4;
            4'b1010:          hgf = 3'd5;
            4'b0110:          hgf = 3'd6;
            4'b1110, 4'b0001,
            4'b0111, 4'b1000: hgf = 3'd7;
            default: begin
                hgf    = 3'd0;
                err_4b = 1'b1;
            end
        endcase
    end

    // K23.7, K27.7, K29.7 and K30.7 use the alternate x.7 code
    assign kx7 = !err_6b && (fghj == 4'b1000 || fghj == 4'b0111) &&
                 (edcba == 5'd23 || edcba == 5'd27 || edcba == 5'd29 || edcba == 5'd30);

    assign data     = {hgf, edcba};
    assign is_k     = k28 || kx7;
    assign code_err = err_6b || err_4b;

endmodule

// ==== rtl/flit_decoder.sv ====
// stage 2 symbol decode, comma selection and header length predecode
`timescale 1ns/100ps
`include "phy_rx_defines.svh"

module flit_decoder import phy_rx_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  enc_word_t     s1_word,
    input  logic          s1_valid,
    input  comma_length_t s1_length,
    output flit_t         s2_flit,
    output logic          s2_flit_valid,
    output comma_sel_t    s2_sel,
    output logic          s2_sel_valid,
    output logic          s2_start,
    output pkt_size_t     s2_size,
    output logic          s2_size_load,
    output logic          s2_code_err
);

    flit_t                   dec_flit;
    logic [`PHY_SYMBOLS-1:0] dec_err;
    logic [`PHY_SYMBOLS-1:0] dec_k;
    frame_state_t            state;
    frame_state_t            n_state;
    flit_t                   n_flit;
    comma_sel_t              n_sel;
    pkt_size_t               hdr_size;
    logic                    n_flit_valid;
    logic                    n_sel_valid;
    logic                    n_start;
    logic                    n_size_load;
    logic                    n_code_err;

    for (genvar i = 0; i < `PHY_SYMBOLS; i++) begin : g_dec
        dec_8b10b u_dec (
            .sym      (s1_word[i*`PHY_SYM_W +: `PHY_SYM_W]),
            .data     (dec_flit[i*`PHY_BYTE_W +: `PHY_BYTE_W]),
            .is_k     (dec_k[i]),
            .code_err (dec_err[i])
        );
    end

    // remaining flits after the header
    assign hdr_size = expected_num_flits(payload_t'(dec_flit)) - pkt_size_t'(1);

    always_comb begin
        n_flit       = '0;
        n_sel        = s2_sel;
        n_state      = state;
        n_flit_valid = 1'b0;
        n_sel_valid  = 1'b0;
        n_start      = 1'b0;
        n_size_load  = 1'b0;
        n_code_err   = 1'b0;
        case (s1_length)
            COMMA_1_FLIT: begin
                n_sel       = comma_code_sel(s1_word[`PHY_SYM_W-1:0]);
                n_sel_valid = 1'b1;
                if (n_sel == START_SEL) begin
                    n_start = 1'b1;
                    n_state = LOOK_FOR_HEADER;
                end else begin
                    n_state = LOOK_FOR_START;
                end
            end
            COMMA_2_FLIT: begin
                n_sel       = comma_code_sel(s1_word[2*`PHY_SYM_W-1:`PHY_SYM_W]);
                n_sel_valid = 1'b1;
                // low payload byte moves up into vc, id and req
                n_flit = {dec_flit[`PHY_BYTE_W-1:0], payload_t'(0)};
            end
            default: begin
                n_flit       = dec_flit;
                n_sel        = DATA_SEL;
                n_flit_valid = 1'b1;
                // a control symbol inside data counts as a bad symbol
                n_code_err = |(dec_err | dec_k);
                if (state == LOOK_FOR_HEADER) begin
                    n_size_load = 1'b1;
                    n_state     = LOOK_FOR_END;
                end
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            s2_flit_valid <= 1'b0;
            s2_sel_valid  <= 1'b0;
            s2_start      <= 1'b0;
            s2_size_load  <= 1'b0;
            s2_code_err   <= 1'b0;
            s2_sel        <= START_SEL;
            state         <= LOOK_FOR_START;
        end else begin
            s2_flit_valid <= s1_valid && n_flit_valid;
            s2_sel_valid  <= s1_valid && n_sel_valid;
            s2_start      <= s1_valid && n_start;
            s2_size_load  <= s1_valid && n_size_load;
            s2_code_err   <= s1_valid && n_code_err;
            if (s1_valid) begin
                s2_sel <= n_sel;
                state  <= n_state;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (s1_valid) begin
            s2_flit <= n_flit;
            s2_size <= hdr_size;
        end
    end

endmodule

// ==== rtl/packet_counter.sv ====
// stage 3 remaining flit count, packet end, packet count and framing check
`timescale 1ns/100ps

module packet_counter import phy_rx_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  flit_t      s2_flit,
    input  logic       s2_flit_valid,
    input  comma_sel_t s2_sel,
    input  logic       s2_sel_valid,
    input  logic       s2_start,
    input  pkt_size_t  s2_size,
    input  logic       s2_size_load,
    input  logic       s2_code_err,
    output flit_t      flit,
    output logic       flit_valid,
    output comma_sel_t comma_sel,
    output logic       sel_valid,
    output logic       pkt_last,
    output pkt_count_t pkt_count,
    output logic       code_err,
    output logic       frame_err
);

    pkt_size_t remaining;
    logic      pkt_open;
    logic      is_end;
    logic      last_in;
    logic      err_in;

    always_comb begin
        is_end = s2_sel_valid && (s2_sel == END_SEL);
        // a single flit packet ends on its own header
        if (s2_size_load) begin
            last_in = s2_flit_valid && (s2_size == '0);
        end else begin
            last_in = s2_flit_valid && pkt_open && (remaining == pkt_size_t'(1));
        end
        err_in = (s2_flit_valid && !pkt_open) ||
                 (is_end && pkt_open) ||
                 (s2_start && pkt_open);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flit_valid <= 1'b0;
            sel_valid  <= 1'b0;
            comma_sel  <= START_SEL;
            pkt_last   <= 1'b0;
            code_err   <= 1'b0;
            frame_err  <= 1'b0;
            pkt_count  <= '0;
            pkt_open   <= 1'b0;
            remaining  <= '0;
        end else begin
            flit_valid <= s2_flit_valid;
            sel_valid  <= s2_sel_valid;
            comma_sel  <= s2_sel;
            pkt_last   <= last_in;
            code_err   <= s2_code_err;
            frame_err  <= err_in;
            if (last_in) begin
                pkt_count <= pkt_count + pkt_count_t'(1);
            end
            // a start inside an open packet reopens it
            if (s2_start) begin
                pkt_open <= 1'b1;
            end else if (last_in || is_end) begin
                pkt_open <= 1'b0;
            end
            if (s2_start || is_end) begin
                remaining <= '0;
            end else if (s2_size_load) begin
                remaining <= s2_size;
            end else if (s2_flit_valid && remaining != '0) begin
                remaining <= remaining - pkt_size_t'(1);
            end
        end
    end

    always_ff @(posedge CLK) begin
        flit <= s2_flit;
    end

endmodule

// ==== rtl/phy_rx_pkg.sv ====
// receive path types, enums, comma codes, comma lookup and flit count function
`include "phy_rx_defines.svh"

package phy_rx_pkg;

    typedef logic [`PHY_SYM_W-1:0] sym_t;
    typedef logic [`PHY_BYTE_W-1:0] byte_t;
    // symbol 0 sits in the lowest bits
    typedef logic [`PHY_SYMBOLS*`PHY_SYM_W-1:0] enc_word_t;
    // {vc, id[1:0], req[4:0], payload[31:0]} from the top down
    typedef logic [`PHY_SYMBOLS*`PHY_BYTE_W-1:0] flit_t;
    typedef logic [31:0] payload_t;
    // wide enough for a long write of 255 data flits plus two header flits
    typedef logic [8:0] pkt_size_t;
    typedef logic [15:0] pkt_count_t;

    typedef enum logic [1:0] {
        COMMA_1_FLIT,
        COMMA_2_FLIT,
        COMMA_DATA
    } comma_length_t;

    typedef enum logic [3:0] {
        START_SEL,
        END_SEL,
        RESEND0_SEL,
        RESEND1_SEL,
        RESEND2_SEL,
        RESEND3_SEL,
        ACK_SEL,
        NACK_SEL,
        DATA_SEL
    } comma_sel_t;

    typedef enum logic [1:0] {
        LOOK_FOR_START,
        LOOK_FOR_HEADER,
        LOOK_FOR_END
    } frame_state_t;

    // codes are {abcdei, fghj}, a in bit 9; RN and RP are the two disparities
    localparam sym_t START_COMMA_RN   = 10'b001111_1010;
    localparam sym_t START_COMMA_RP   = 10'b110000_0101;
    localparam sym_t END_COMMA_RN     = 10'b001111_1000;
    localparam sym_t END_COMMA_RP     = 10'b110000_0111;
    localparam sym_t RESEND0_COMMA_RN = 10'b001111_0100;
    localparam sym_t RESEND0_COMMA_RP = 10'b110000_1011;
    localparam sym_t RESEND1_COMMA_RN = 10'b001111_1001;
    localparam sym_t RESEND1_COMMA_RP = 10'b110000_0110;
    localparam sym_t RESEND2_COMMA_RN = 10'b001111_0101;
    localparam sym_t RESEND2_COMMA_RP = 10'b110000_1010;
    localparam sym_t RESEND3_COMMA_RN = 10'b001111_0011;
    localparam sym_t RESEND3_COMMA_RP = 10'b110000_1100;
    localparam sym_t ACK_COMMA_RN     = 10'b001111_0010;
    localparam sym_t ACK_COMMA_RP     = 10'b110000_1101;
    localparam sym_t NACK_COMMA_RN    = 10'b001111_0110;
    localparam sym_t NACK_COMMA_RP    = 10'b110000_1001;

    // header format field, payload bits 31:28
    localparam logic [3:0] FMT_LONG_READ   = 4'h0;
    localparam logic [3:0] FMT_LONG_WRITE  = 4'h1;
    localparam logic [3:0] FMT_MEM_RESP    = 4'h2;
    localparam logic [3:0] FMT_MSG         = 4'h3;
    localparam logic [3:0] FMT_SHORT_READ  = 4'h4;
    localparam logic [3:0] FMT_SHORT_WRITE = 4'h5;

    // DATA_SEL when the symbol is no comma at all
    function automatic comma_sel_t comma_code_sel(input sym_t sym);
        comma_sel_t sel;
        case (sym)
            START_COMMA_RN, START_COMMA_RP:     sel = START_SEL;
            END_COMMA_RN, END_COMMA_RP:         sel = END_SEL;
            RESEND0_COMMA_RN, RESEND0_COMMA_RP: sel = RESEND0_SEL;
            RESEND1_COMMA_RN, RESEND1_COMMA_RP: sel = RESEND1_SEL;
            RESEND2_COMMA_RN, RESEND2_COMMA_RP: sel = RESEND2_SEL;
            RESEND3_COMMA_RN, RESEND3_COMMA_RP: sel = RESEND3_SEL;
            ACK_COMMA_RN, ACK_COMMA_RP:         sel = ACK_SEL;
            NACK_COMMA_RN, NACK_COMMA_RP:       sel = NACK_SEL;
            default:                            sel = DATA_SEL;
        endcase
        return sel;
    endfunction

    // total flits of a packet, header included
    function automatic pkt_size_t expected_num_flits(input payload_t payload);
        pkt_size_t len;
        pkt_size_t long_len;
        pkt_size_t short_len;
        pkt_size_t num;
        len = pkt_size_t'(payload[7:0]);
        long_len = (len == '0) ? pkt_size_t'(`PHY_LONG_LEN_DEFAULT) : len;
        short_len = (payload[3:0] == '0) ? pkt_size_t'(`PHY_SHORT_LEN_DEFAULT)
                                         : pkt_size_t'(payload[3:0]);
        case (payload[31:28])
            FMT_SHORT_READ:       num = pkt_size_t'(1);
            FMT_LONG_READ:        num = pkt_size_t'(2);
            FMT_SHORT_WRITE:      num = pkt_size_t'(1) + short_len;
            FMT_LONG_WRITE:       num = pkt_size_t'(2) + long_len;
            FMT_MSG, FMT_MEM_RESP: num = pkt_size_t'(1) + long_len;
            default:              num = pkt_size_t'(1);
        endcase
        return num;
    endfunction

endpackage

// ==== rtl/phy_rx_top.sv ====
// receive path top with classifier, decoder and packet counter stages
`timescale 1ns/100ps

module phy_rx_top import phy_rx_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  enc_word_t  enc_word,
    input  logic       word_valid,
    output flit_t      flit,
    output logic       flit_valid,
    output comma_sel_t comma_sel,
    output logic       sel_valid,
    output logic       pkt_last,
    output pkt_count_t pkt_count,
    output logic       code_err,
    output logic       frame_err
);

    enc_word_t     s1_word;
    logic          s1_valid;
    comma_length_t s1_length;

    flit_t      s2_flit;
    logic       s2_flit_valid;
    comma_sel_t s2_sel;
    logic       s2_sel_valid;
    logic       s2_start;
    pkt_size_t  s2_size;
    logic       s2_size_load;
    logic       s2_code_err;

    comma_classifier u_classifier (
        .CLK        (CLK),
        .nRST       (nRST),
        .enc_word   (enc_word),
        .word_valid (word_valid),
        .s1_word    (s1_word),
        .s1_valid   (s1_valid),
        .s1_length  (s1_length)
    );

    flit_decoder u_decoder (
        .CLK           (CLK),
        .nRST          (nRST),
        .s1_word       (s1_word),
        .s1_valid      (s1_valid),
        .s1_length     (s1_length),
        .s2_flit       (s2_flit),
        .s2_flit_valid (s2_flit_valid),
        .s2_sel        (s2_sel),
        .s2_sel_valid  (s2_sel_valid),
        .s2_start      (s2_start),
        .s2_size       (s2_size),
        .s2_size_load  (s2_size_load),
        .s2_code_err   (s2_code_err)
    );

    packet_counter u_counter (
        .CLK           (CLK),
        .nRST          (nRST),
        .s2_flit       (s2_flit),
        .s2_flit_valid (s2_flit_valid),
        .s2_sel        (s2_sel),
        .s2_sel_valid  (s2_sel_valid),
        .s2_start      (s2_start),
        .s2_size       (s2_size),
        .s2_size_load  (s2_size_load),
        .s2_code_err   (s2_code_err),
        .flit          (flit),
        .flit_valid    (flit_valid),
        .comma_sel     (comma_sel),
        .sel_valid     (sel_valid),
        .pkt_last      (pkt_last),
        .pkt_count     (pkt_count),
        .code_err      (code_err),
        .frame_err     (frame_err)
    );

endmodule
